//--- design/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] data_t;
  typedef logic [31:0]     instr_t;

  typedef enum logic [6:0] {
    op_rtype  = 7'b0110011,
    op_itype  = 7'b0010011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111
  } opcode_t;

  // alu class chosen by the fsm, refined by funct3/funct7 in decode.
  typedef enum logic [1:0] {
    alu_op_add   = 2'd0,
    alu_op_sub   = 2'd1,
    alu_op_funct = 2'd2
  } alu_op_t;

  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_and = 4'd2,
    alu_or  = 4'd3,
    alu_slt = 4'd4
  } alu_ctrl_t;

  typedef enum logic [1:0] {
    src_a_zero   = 2'd0,
    src_a_rs1    = 2'd1,
    src_a_old_pc = 2'd2
  } src_a_t;

  typedef enum logic [1:0] {
    src_b_rs2  = 2'd0,
    src_b_four = 2'd1,
    src_b_imm  = 2'd2
  } src_b_t;

  typedef enum logic [1:0] {
    result_alu_out  = 2'd0,
    result_mem_data = 2'd1,
    result_old_pc   = 2'd2
  } result_src_t;

  typedef enum logic {
    pc_plus4  = 1'b0,
    pc_target = 1'b1
  } pc_src_t;

  typedef enum logic [3:0] {
    s_fetch     = 4'd0,
    s_decode    = 4'd1,
    s_exec_r    = 4'd2,
    s_exec_i    = 4'd3,
    s_mem_adr   = 4'd4,
    s_mem_read  = 4'd5,
    s_mem_wb    = 4'd6,
    s_mem_write = 4'd7,
    s_alu_wb    = 4'd8,
    s_branch    = 4'd9,
    s_jal       = 4'd10
  } fsm_state_t;

endpackage

//--- design/control_fsm.sv
`timescale 1ns/100ps

module control_fsm import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  opcode_t     opcode,
  input  logic        zero,
  input  logic        fetch_gnt,
  input  logic        data_gnt,
  output logic        fetch_req,
  output logic        data_req,
  output logic        data_we,
  output logic        ir_write,
  output logic        pc_update,
  output pc_src_t     pc_src,
  output logic        reg_write,
  output src_a_t      alu_src_a,
  output src_b_t      alu_src_b,
  output alu_op_t     alu_op,
  output result_src_t result_src
);

  fsm_state_t state;
  fsm_state_t state_next;
  logic       run; // low for the reset cycles, keeps fetch quiet.

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= s_fetch;
      run   <= 1'b0;
    end else begin
      state <= state_next;
      run   <= 1'b1;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      s_fetch: begin
        if (fetch_gnt) begin
          state_next = s_decode;
        end
      end
      s_decode: begin
        case (opcode)
          op_rtype:          state_next = s_exec_r;
          op_itype:          state_next = s_exec_i;
          op_load, op_store: state_next = s_mem_adr;
          op_branch:         state_next = s_branch;
          op_jal:            state_next = s_jal;
          default:           state_next = s_fetch; // unsupported, skipped.
        endcase
      end
      s_exec_r, s_exec_i, s_jal: state_next = s_alu_wb;
      s_mem_adr:   state_next = (opcode == op_load) ? s_mem_read : s_mem_write;
      s_mem_read: begin
        if (data_gnt) begin
          state_next = s_mem_wb;
        end
      end
      s_mem_write: begin
        if (data_gnt) begin
          state_next = s_fetch;
        end
      end
      default:     state_next = s_fetch; // wb and branch states.
    endcase
  end

  always_comb begin
    fetch_req  = 1'b0;
    data_req   = 1'b0;
    data_we    = 1'b0;
    ir_write   = 1'b0;
    pc_update  = 1'b0;
    pc_src     = pc_plus4;
    reg_write  = 1'b0;
    alu_src_a  = src_a_rs1;
    alu_src_b  = src_b_rs2;
    alu_op     = alu_op_add;
    result_src = result_alu_out;
    case (state)
      s_fetch:  fetch_req = run;
      s_decode: begin
        ir_write  = 1'b1;
        pc_update = 1'b1; // pc + 4 through the alu.
        alu_src_a = src_a_old_pc;
        alu_src_b = src_b_four;
      end
      s_exec_r: alu_op = alu_op_funct;
      s_exec_i: begin
        alu_src_b = src_b_imm;
        alu_op    = alu_op_funct;
      end
      s_mem_adr: alu_src_b = src_b_imm;
      s_mem_read: begin
        alu_src_b = src_b_imm; // alu_out keeps the address until the grant.
        data_req  = 1'b1;
      end
      s_mem_write: begin
        alu_src_b = src_b_imm;
        data_req  = 1'b1;
        data_we   = 1'b1;
      end
      s_mem_wb: begin
        reg_write  = 1'b1;
        result_src = result_mem_data;
      end
      s_alu_wb: reg_write = 1'b1;
      s_branch: begin
        alu_op    = alu_op_sub;
        pc_src    = pc_target;
        pc_update = zero; // taken only on equal operands.
      end
      s_jal: begin
        alu_src_a = src_a_old_pc; // link value old pc + 4.
        alu_src_b = src_b_four;
        pc_src    = pc_target;
        pc_update = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- design/fetch.sv
`timescale 1ns/100ps

module fetch import rv_pkg::*; #(
  parameter data_t reset_pc = '0
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    fetch_gnt,
  input  logic    ir_write,
  input  logic    pc_update,
  input  pc_src_t pc_src,
  input  data_t   pc_next,
  input  data_t   target,
  input  data_t   mem_rdata,
  output data_t   pc,
  output data_t   old_pc,
  output instr_t  instr
);

  instr_t ir;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= reset_pc;
      old_pc <= reset_pc;
    end else begin
      if (pc_update) begin
        pc <= (pc_src == pc_target) ? target : pc_next;
      end
      // address of the word the granted fetch returns.
      if (fetch_gnt) begin
        old_pc <= pc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ir_write) begin
      ir <= mem_rdata;
    end
  end

  // the word is visible to decode while it is being written.
  assign instr = ir_write ? mem_rdata : ir;

endmodule

//--- design/instruction_decode.sv
`timescale 1ns/100ps

module instruction_decode import rv_pkg::*; #(
  parameter int reg_count = 32
) (
  input  logic      clk,
  input  logic      rst,
  input  instr_t    instr,
  input  logic      reg_write,
  input  alu_op_t   alu_op,
  input  data_t     result,
  output opcode_t   opcode,
  output alu_ctrl_t alu_ctrl,
  output data_t     rs1,
  output data_t     rs2,
  output data_t     imm_ext
);

  localparam int rf_aw = $clog2(reg_count);

  data_t            regs [reg_count];
  logic [rf_aw-1:0] rs1_idx;
  logic [rf_aw-1:0] rs2_idx;
  logic [rf_aw-1:0] rd_idx;
  logic [2:0]       funct3;
  data_t            rs1_rd;
  data_t            rs2_rd;

  assign opcode  = opcode_t'(instr[6:0]);
  assign funct3  = instr[14:12];
  assign rd_idx  = instr[7 +: rf_aw];
  assign rs1_idx = instr[15 +: rf_aw];
  assign rs2_idx = instr[20 +: rf_aw];

  assign rs1_rd = (rs1_idx == '0) ? '0 : regs[rs1_idx]; // x0 reads zero.
  assign rs2_rd = (rs2_idx == '0) ? '0 : regs[rs2_idx];

  always_ff @(posedge clk) begin
    if (reg_write && rd_idx != '0) begin
      regs[rd_idx] <= result;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rs1 <= '0;
      rs2 <= '0;
    end else begin
      rs1 <= rs1_rd;
      rs2 <= rs2_rd;
    end
  end

  always_comb begin
    case (opcode)
      op_itype, op_load: imm_ext = {{20{instr[31]}}, instr[31:20]};
      op_store:  imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      op_branch: imm_ext = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      op_jal:    imm_ext = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default:   imm_ext = '0;
    endcase
  end

  always_comb begin
    case (alu_op)
      alu_op_add: alu_ctrl = alu_add;
      alu_op_sub: alu_ctrl = alu_sub;
      default: begin
        case (funct3)
          3'b000:  alu_ctrl = (opcode == op_rtype && instr[30]) ? alu_sub : alu_add;
          3'b010:  alu_ctrl = alu_slt;
          3'b110:  alu_ctrl = alu_or;
          3'b111:  alu_ctrl = alu_and;
          default: alu_ctrl = alu_add;
        endcase
      end
    endcase
  end

endmodule

//--- design/alu.sv
`timescale 1ns/100ps

module alu import rv_pkg::*; (
  input  data_t     a,
  input  data_t     b,
  input  alu_ctrl_t alu_ctrl,
  output data_t     y,
  output logic      zero
);

  data_t diff;

  assign diff = a - b;

  always_comb begin
    case (alu_ctrl)
      alu_add: y = a + b;
      alu_sub: y = diff;
      alu_and: y = a & b;
      alu_or:  y = a | b;
      alu_slt: y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)}; // signed compare.
      default: y = '0;
    endcase
  end

  assign zero = (y == '0);

endmodule

//--- design/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter import rv_pkg::*; #(
  parameter int mem_words = 256
) (
  input  logic                         host_req,
  input  logic                         host_we,
  input  data_t                        host_addr,
  input  data_t                        host_wdata,
  input  logic                         data_req,
  input  logic                         data_we,
  input  data_t                        data_addr,
  input  data_t                        data_wdata,
  input  logic                         fetch_req,
  input  data_t                        fetch_addr,
  output logic                         host_gnt,
  output logic                         data_gnt,
  output logic                         fetch_gnt,
  output logic                         mem_en,
  output logic                         mem_we,
  output logic [$clog2(mem_words)-1:0] mem_addr,
  output data_t                        mem_wdata
);

  localparam int addr_w = $clog2(mem_words);

  // host first, then the core data path, then fetch.
  assign host_gnt  = host_req;
  assign data_gnt  = data_req & ~host_req;
  assign fetch_gnt = fetch_req & ~host_req & ~data_req;

  assign mem_en = host_req | data_req | fetch_req;

  always_comb begin
    mem_we    = 1'b0;
    mem_addr  = fetch_addr[addr_w+1:2]; // byte address to word index.
    mem_wdata = data_wdata;
    if (host_gnt) begin
      mem_we    = host_we;
      mem_addr  = host_addr[addr_w+1:2];
      mem_wdata = host_wdata;
    end else if (data_gnt) begin
      mem_we    = data_we;
      mem_addr  = data_addr[addr_w+1:2];
    end
  end

endmodule

//--- design/unified_mem.sv
`timescale 1ns/100ps

module unified_mem import rv_pkg::*; #(
  parameter int mem_words = 256
) (
  input  logic                         clk,
  input  logic                         en,
  input  logic                         we,
  input  logic [$clog2(mem_words)-1:0] addr,
  input  data_t                        wdata,
  output data_t                        rdata
);

  data_t mem [mem_words];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr]; // holds when no access is granted.
    end
  end

endmodule

//--- design/top.sv
`timescale 1ns/100ps

module top import rv_pkg::*; #(
  parameter int    mem_words = 256,
  parameter data_t reset_pc  = 32'h0,
  parameter int    reg_count = 32
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  host_req,
  input  logic  host_we,
  input  data_t host_addr,
  input  data_t host_wdata,
  output logic  host_gnt,
  output data_t host_rdata
);

  localparam int addr_w = $clog2(mem_words);

  opcode_t     opcode;
  instr_t      instr;
  alu_ctrl_t   alu_ctrl;
  alu_op_t     alu_op;
  pc_src_t     pc_src;
  src_a_t      alu_src_a;
  src_b_t      alu_src_b;
  result_src_t result_src;

  logic fetch_req, fetch_gnt;
  logic data_req, data_we, data_gnt;
  logic ir_write, pc_update, reg_write, zero;
  logic mem_en, mem_we;
  logic [addr_w-1:0] mem_addr;

  data_t pc, old_pc, target, imm_ext, rs1, rs2;
  data_t src_a, src_b, alu_y, alu_out, result;
  data_t mem_wdata, mem_rdata;

  control_fsm u_control_fsm (
    .clk, .rst, .opcode, .zero, .fetch_gnt, .data_gnt, .fetch_req, .data_req, .data_we,
    .ir_write, .pc_update, .pc_src, .reg_write, .alu_src_a, .alu_src_b, .alu_op, .result_src
  );

  fetch #(.reset_pc(reset_pc)) u_fetch (
    .clk, .rst, .fetch_gnt, .ir_write, .pc_update, .pc_src, .pc_next(alu_y), .target,
    .mem_rdata, .pc, .old_pc, .instr
  );

  instruction_decode #(.reg_count(reg_count)) u_instruction_decode (
    .clk, .rst, .instr, .reg_write, .alu_op, .result, .opcode, .alu_ctrl, .rs1, .rs2, .imm_ext
  );

  alu u_alu (.a(src_a), .b(src_b), .alu_ctrl, .y(alu_y), .zero);

  mem_arbiter #(.mem_words(mem_words)) u_mem_arbiter (
    .host_req, .host_we, .host_addr, .host_wdata,
    .data_req, .data_we, .data_addr(alu_out), .data_wdata(rs2),
    .fetch_req, .fetch_addr(pc), .host_gnt, .data_gnt, .fetch_gnt,
    .mem_en, .mem_we, .mem_addr, .mem_wdata
  );

  unified_mem #(.mem_words(mem_words)) u_unified_mem (
    .clk, .en(mem_en), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
  );

  assign target     = old_pc + imm_ext; // branch and jal target.
  assign host_rdata = mem_rdata;

  always_ff @(posedge clk) begin
    alu_out <= alu_y;
  end

  always_comb begin
    case (alu_src_a)
      src_a_rs1:    src_a = rs1;
      src_a_old_pc: src_a = old_pc;
      default:      src_a = '0;
    endcase
  end

  always_comb begin
    case (alu_src_b)
      src_b_rs2:  src_b = rs2;
      src_b_four: src_b = 32'd4;
      default:    src_b = imm_ext;
    endcase
  end

  // the ram output register is the memory data register.
  always_comb begin
    case (result_src)
      result_mem_data: result = mem_rdata;
      result_old_pc:   result = old_pc;
      default:         result = alu_out;
    endcase
  end

endmodule

//--- testbench/core_sva.sv
`timescale 1ns/100ps

module core_sva import rv_pkg::*; (
  input logic   clk,
  input logic   rst,
  input logic   host_req,
  input logic   host_gnt,
  input logic   data_req,
  input logic   data_we,
  input logic   data_gnt,
  input data_t  data_addr,
  input logic   fetch_req,
  input logic   fetch_gnt,
  input data_t  pc,
  input instr_t instr,
  input data_t  imm_ext,
  input data_t  mem_wdata
);

  grant_onehot: assert property (@(posedge clk) $onehot0({host_gnt, data_gnt, fetch_gnt}))
    else $error("more than one memory grant in a cycle");

  host_first: assert property (@(posedge clk) host_req |-> host_gnt && !data_gnt && !fetch_gnt)
    else $error("host request not granted first");

  grant_has_req: assert property (@(posedge clk) (data_gnt |-> data_req) and (fetch_gnt |-> fetch_req))
    else $error("grant without a request");

  // address and direction stay put while a request waits.
  data_hold: assert property (@(posedge clk) disable iff (rst)
    data_req && !data_gnt |=> data_req && $stable(data_we) && $stable(data_addr))
    else $error("data request dropped or changed before its grant");

  fetch_hold: assert property (@(posedge clk) disable iff (rst)
    fetch_req && !fetch_gnt |=> fetch_req && $stable(pc))
    else $error("fetch request dropped or changed before its grant");

  // x0 as base gives the bare offset, x0 as store data gives zero.
  x0_base: assert property (@(posedge clk) disable iff (rst)
    data_gnt && instr[19:15] == 5'd0 |-> data_addr == imm_ext)
    else $error("x0 base register read nonzero");

  x0_store: assert property (@(posedge clk) disable iff (rst)
    data_gnt && data_we && instr[24:20] == 5'd0 |-> mem_wdata == '0)
    else $error("x0 stored as nonzero data");

endmodule

bind top core_sva sva_i (
  .clk      (clk),
  .rst      (rst),
  .host_req (host_req),
  .host_gnt (host_gnt),
  .data_req (data_req),
  .data_we  (data_we),
  .data_gnt (data_gnt),
  .data_addr(alu_out),
  .fetch_req(fetch_req),
  .fetch_gnt(fetch_gnt),
  .pc       (pc),
  .instr    (instr),
  .imm_ext  (imm_ext),
  .mem_wdata(mem_wdata)
);

//--- testbench/tb_top.sv
`timescale 1ns/100ps

module tb_top import rv_pkg::*; ;

  localparam int    mem_words  = 256;
  localparam data_t done_addr  = 32'h0000_027c;
  localparam data_t done_value = 32'h0000_005d;

  logic  clk;
  logic  rst;
  logic  host_req;
  logic  host_we;
  data_t host_addr;
  data_t host_wdata;
  logic  host_gnt;
  data_t host_rdata;

  int    errors;
  int    checks;
  data_t prog[$];
  data_t image[mem_words];

  top #(
    .mem_words(mem_words),
    .reset_pc (32'h0),
    .reg_count(32)
  ) dut_i (
    .clk       (clk),
    .rst       (rst),
    .host_req  (host_req),
    .host_we   (host_we),
    .host_addr (host_addr),
    .host_wdata(host_wdata),
    .host_gnt  (host_gnt),
    .host_rdata(host_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #400000;
    $display("simulation ran past its time limit");
    $display("Some tests failed");
    $finish;
  end

  function automatic data_t r_form(input logic [6:0] f7, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3,
                                   input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic data_t i_form(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd,
                                   input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic data_t s_form(input logic [11:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic data_t b_form(input logic [12:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic data_t j_form(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic data_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic data_t fill_word(input int idx);
    return 32'ha5c3_0000 | data_t'(idx); // unique per word index.
  endfunction

  task automatic check_word(input data_t addr, input data_t got, input data_t exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("[ERROR] host_rdata at %08h: got %08h, expected %08h", addr, got, exp);
    end
  endtask

  task automatic read_word(input data_t addr, output data_t val);
    int n;
    @(posedge clk);
    host_req <= 1'b1;
    host_we  <= 1'b0;
    host_addr <= addr;
    n = 0;
    @(negedge clk);
    while (!host_gnt && n < 20) begin
      @(negedge clk);
      n++;
    end
    checks++;
    assert (host_gnt && n == 0) else begin
      errors++;
      $display("host_gnt did not come in the cycle of host_req, waited %0d cycles", n);
    end
    @(posedge clk);
    host_req <= 1'b0;
    @(negedge clk);
    val = host_rdata; // one cycle after the grant.
  endtask

  task automatic build_program(input logic [11:0] c1, input logic [11:0] c2,
                               input logic [11:0] c3, output int jal_pc);
    prog.delete();
    prog.push_back(i_form(c1, 5'd0, 3'd0, 5'd1, 7'b0010011));
    prog.push_back(i_form(c2, 5'd0, 3'd0, 5'd2, 7'b0010011));
    prog.push_back(i_form(c3, 5'd1, 3'd0, 5'd3, 7'b0010011));
    prog.push_back(r_form(7'h00, 5'd2, 5'd1, 3'd0, 5'd4)); // add.
    prog.push_back(r_form(7'h20, 5'd2, 5'd1, 3'd0, 5'd5)); // sub.
    prog.push_back(r_form(7'h00, 5'd2, 5'd1, 3'd7, 5'd6));
    prog.push_back(r_form(7'h00, 5'd2, 5'd1, 3'd6, 5'd7));
    prog.push_back(r_form(7'h00, 5'd2, 5'd1, 3'd2, 5'd8)); // slt x1, x2.
    prog.push_back(r_form(7'h00, 5'd1, 5'd2, 3'd2, 5'd9)); // slt x2, x1.
    for (int k = 1; k <= 9; k++) begin
      prog.push_back(s_form(12'(32'h200 + 4 * (k - 1)), 5'(k), 5'd0));
    end
    prog.push_back(s_form(12'h240, 5'd7, 5'd0));
    prog.push_back(i_form(12'h240, 5'd0, 3'b010, 5'd10, 7'b0000011)); // lw.
    prog.push_back(s_form(12'h244, 5'd10, 5'd0));
    prog.push_back(i_form(12'h07b, 5'd0, 3'd0, 5'd0, 7'b0010011)); // write to x0.
    prog.push_back(s_form(12'h248, 5'd0, 5'd0));
    prog.push_back(i_form(12'h001, 5'd0, 3'd0, 5'd11, 7'b0010011)); // marker value.
    prog.push_back(b_form(13'd8, 5'd1, 5'd1)); // taken.
    prog.push_back(s_form(12'h250, 5'd11, 5'd0));
    prog.push_back(s_form(12'h254, 5'd11, 5'd0));
    prog.push_back(b_form(13'd8, 5'd2, 5'd1)); // not taken.
    prog.push_back(s_form(12'h258, 5'd11, 5'd0));
    jal_pc = prog.size() * 4;
    prog.push_back(j_form(21'd8, 5'd12));
    prog.push_back(s_form(12'h260, 5'd11, 5'd0));
    prog.push_back(s_form(12'h264, 5'd11, 5'd0));
    prog.push_back(s_form(12'h268, 5'd12, 5'd0));
    prog.push_back(i_form(12'h05d, 5'd0, 3'd0, 5'd13, 7'b0010011));
    prog.push_back(s_form(12'h27c, 5'd13, 5'd0));
    prog.push_back(j_form(21'd0, 5'd0)); // jal to self.
  endtask

  // random host reads of program words while polling the done word.
  task automatic run_until_done();
    int    polls;
    int    idx;
    data_t got;
    logic  finished;
    finished = 1'b0;
    polls = 0;
    while (!finished && polls < 300) begin
      repeat ($urandom_range(0, 5)) @(posedge clk);
      idx = $urandom_range(0, prog.size() - 1);
      read_word(data_t'(idx * 4), got);
      check_word(data_t'(idx * 4), got, image[idx]);
      read_word(done_addr, got);
      finished = (got == done_value);
      polls++;
    end
    if (!finished) begin
      errors++;
      $display("program never wrote its done word");
    end
  endtask

  initial begin
    logic [11:0] c1;
    logic [11:0] c2;
    logic [11:0] c3;
    data_t       ev[10];
    data_t       got;
    int          jal_pc;
    rst        = 1'b1;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    errors     = 0;
    checks     = 0;
    void'($urandom(32'hc78541a6));
    c1 = 12'($urandom);
    c2 = 12'($urandom);
    c3 = 12'($urandom);
    if (c2 == c1) begin
      c2 = c1 ^ 12'h001; // beq not-taken needs x1 != x2.
    end
    build_program(c1, c2, c3, jal_pc);
    for (int i = 0; i < mem_words; i++) begin
      image[i] = (i < prog.size()) ? prog[i] : fill_word(i);
    end

    // host_req stays high over the whole load, so the core cannot fetch.
    fork
      begin
        repeat (5) @(posedge clk);
        rst <= 1'b0;
      end
      begin
        for (int i = 0; i < mem_words; i++) begin
          @(posedge clk);
          host_req   <= 1'b1;
          host_we    <= 1'b1;
          host_addr  <= data_t'(i * 4);
          host_wdata <= image[i];
        end
        @(posedge clk);
        host_req <= 1'b0;
        host_we  <= 1'b0;
      end
    join

    run_until_done();

    ev[1] = sext12(c1);
    ev[2] = sext12(c2);
    ev[3] = ev[1] + sext12(c3);
    ev[4] = ev[1] + ev[2];
    ev[5] = ev[1] - ev[2];
    ev[6] = ev[1] & ev[2];
    ev[7] = ev[1] | ev[2];
    ev[8] = ($signed(ev[1]) < $signed(ev[2])) ? 32'd1 : 32'd0;
    ev[9] = ($signed(ev[2]) < $signed(ev[1])) ? 32'd1 : 32'd0;
    for (int k = 1; k <= 9; k++) begin
      read_word(data_t'(32'h200 + 4 * (k - 1)), got);
      check_word(data_t'(32'h200 + 4 * (k - 1)), got, ev[k]);
    end
    read_word(32'h240, got);
    check_word(32'h240, got, ev[7]);
    read_word(32'h244, got);
    check_word(32'h244, got, ev[7]);
    read_word(32'h248, got);
    check_word(32'h248, got, 32'h0);
    read_word(32'h250, got);
    check_word(32'h250, got, fill_word(32'h250 >> 2)); // skipped by beq.
    read_word(32'h254, got);
    check_word(32'h254, got, 32'h1);
    read_word(32'h258, got);
    check_word(32'h258, got, 32'h1);
    read_word(32'h260, got);
    check_word(32'h260, got, fill_word(32'h260 >> 2)); // skipped by jal.
    read_word(32'h264, got);
    check_word(32'h264, got, 32'h1);
    read_word(32'h268, got);
    check_word(32'h268, got, data_t'(jal_pc + 4));
    read_word(done_addr, got);
    check_word(done_addr, got, done_value);

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- build.f
design/rv_pkg.sv
design/control_fsm.sv
design/fetch.sv
design/instruction_decode.sv
design/alu.sv
design/mem_arbiter.sv
design/unified_mem.sv
design/top.sv
testbench/core_sva.sv
testbench/tb_top.sv

//--- build.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_top -Mdir obj_dir -o tb_top_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

output=$(./obj_dir/tb_top_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1
